//--- flist.f
rtl/scalar_cast_pkg.sv
rtl/int_scalar_caster.sv
rtl/int_to_bfloat16_caster.sv
rtl/bfloat16_to_int_caster.sv
rtl/cast_control.sv
rtl/scalar_cast_unit.sv
testbench/tb_scalar_cast_unit.sv

//--- rtl/bfloat16_to_int_caster.sv
`timescale 1ns/1ps
`default_nettype none

module bfloat16_to_int_caster
	import scalar_cast_pkg::*;
(
	input logic clk,
	input scalar_word_u operand,
	input int_size_e dst_size,
	input logic is_signed,
	output scalar_word_u data
);

	// exponent at which the mantissa lsb has a weight of one.
	localparam logic [7:0] point_exp = bf16_bias + 8'd7;

	bf16_view_t bf;
	logic [63:0] significand;
	logic [63:0] magnitude;
	logic [63:0] signed_value;
	logic [7:0] range_limit;
	logic out_of_range;
	logic sign_reject;
	scalar_word_u int_word;

	assign bf = operand.bf16;

	// fractions, subnormals and zero shift out entirely to the right.
	always_comb
	begin
		significand = {56'd0, 1'b1, bf.mantissa};
		if (bf.exponent >= point_exp)
		begin
			magnitude = significand << (bf.exponent - point_exp);
		end
		else
		begin
			magnitude = significand >> (point_exp - bf.exponent);
		end
	end

	always_comb
	begin
		range_limit = is_signed ? bf16_bias + 8'd63 : bf16_bias + 8'd64;
		out_of_range = (bf.exponent == bf16_exp_max) || (bf.exponent >= range_limit);
		sign_reject = bf.sign && !is_signed;
		signed_value = bf.sign ? ~magnitude + 64'd1 : magnitude;
	end

	always_comb
	begin
		if (out_of_range || sign_reject)
		begin
			int_word.int_val = 64'd0;
		end
		else
		begin
			int_word.int_val = low_bits(signed_value, dst_size);
		end
	end

	always_ff @(posedge clk)
	begin
		data <= int_word;
	end

endmodule

`default_nettype wire

//--- rtl/cast_control.sv
`timescale 1ns/1ps
`default_nettype none

module cast_control
	import scalar_cast_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req_valid,
	input cast_kind_e req_kind,
	input scalar_word_u int_data,
	input scalar_word_u to_bf16_data,
	input scalar_word_u from_bf16_data,
	output cast_result_t result
);

	logic valid_q;
	cast_kind_e kind_q;

	// these registers run alongside the one-cycle caster stage.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_q <= 1'b0;
			kind_q <= kind_int_to_int;
		end
		else
		begin
			valid_q <= req_valid;
			if (req_valid)
			begin
				kind_q <= req_kind;
			end
		end
	end

	always_comb
	begin
		result.valid = valid_q;
		case (kind_q)
		kind_int_to_bf16:
		begin
			result.data = to_bf16_data;
		end
		kind_bf16_to_int:
		begin
			result.data = from_bf16_data;
		end
		default:
		begin
			result.data = int_data; // reserved code lands here too.
		end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/int_scalar_caster.sv
`timescale 1ns/1ps
`default_nettype none

module int_scalar_caster
	import scalar_cast_pkg::*;
(
	input logic clk,
	input scalar_word_u operand,
	input int_size_e src_size,
	input int_size_e dst_size,
	input logic is_signed,
	output scalar_word_u data
);

	logic [63:0] src_zext;
	logic [63:0] src_sext;
	logic [63:0] extended;
	logic [63:0] cast_value;
	logic widen;

	// first level of the decode works on the source size.
	always_comb
	begin
		src_zext = low_bits(operand.int_val, src_size);
		src_sext = sign_extend(operand.int_val, src_size);
	end

	always_comb
	begin
		widen = dst_size > src_size;
		if (widen && is_signed)
		begin
			extended = src_sext;
		end
		else
		begin
			extended = src_zext; // narrowing only ever keeps source bits.
		end
	end

	// second level trims to the destination size.
	always_comb
	begin
		case (dst_size)
		size_8:
		begin
			cast_value = {56'd0, extended[7:0]};
		end
		size_16:
		begin
			cast_value = {48'd0, extended[15:0]};
		end
		size_32:
		begin
			cast_value = {32'd0, extended[31:0]};
		end
		default:
		begin
			cast_value = extended;
		end
		endcase
	end

	always_ff @(posedge clk)
	begin
		data.int_val <= cast_value;
	end

endmodule

`default_nettype wire

//--- rtl/int_to_bfloat16_caster.sv
`timescale 1ns/1ps
`default_nettype none

module int_to_bfloat16_caster
	import scalar_cast_pkg::*;
(
	input logic clk,
	input scalar_word_u operand,
	input int_size_e src_size,
	input logic is_signed,
	output scalar_word_u data
);

	logic [63:0] src_value;
	logic negative;
	logic [63:0] magnitude;
	logic nonzero;
	logic [5:0] lead_pos;
	logic [63:0] normalized;
	scalar_word_u bf16_word;

	always_comb
	begin
		if (is_signed)
		begin
			src_value = sign_extend(operand.int_val, src_size);
		end
		else
		begin
			src_value = low_bits(operand.int_val, src_size);
		end
	end

	// the most negative 64-bit value negates to 2^63, which still fits unsigned.
	always_comb
	begin
		negative = is_signed && src_value[63];
		if (negative)
		begin
			magnitude = ~src_value + 64'd1;
		end
		else
		begin
			magnitude = src_value;
		end
		nonzero = |magnitude;
	end

	// priority search for the leading one, the highest set bit wins.
	always_comb
	begin
		lead_pos = 6'd0;
		for (int i = 0; i < 64; i++)
		begin
			if (magnitude[i])
			begin
				lead_pos = 6'(i);
			end
		end
	end

	always_comb
	begin
		normalized = magnitude << (6'd63 - lead_pos); // leading one lands on bit 63.
		bf16_word = '0;
		if (nonzero)
		begin
			bf16_word.bf16.sign = negative;
			bf16_word.bf16.exponent = bf16_bias + {2'b00, lead_pos};
			bf16_word.bf16.mantissa = normalized[62:56]; // lower bits are dropped.
		end
	end

	always_ff @(posedge clk)
	begin
		data <= bf16_word;
	end

endmodule

`default_nettype wire

//--- rtl/scalar_cast_pkg.sv
`default_nettype none

package scalar_cast_pkg;

	typedef enum logic [1:0]
	{
		size_8 = 2'd0,
		size_16 = 2'd1,
		size_32 = 2'd2,
		size_64 = 2'd3
	} int_size_e;

	// code 3 is reserved and behaves like int to int.
	typedef enum logic [1:0]
	{
		kind_int_to_int = 2'd0,
		kind_int_to_bf16 = 2'd1,
		kind_bf16_to_int = 2'd2
	} cast_kind_e;

	localparam logic [7:0] bf16_bias = 8'd127;
	localparam logic [7:0] bf16_exp_max = 8'hff; // infinities and nans.

	typedef struct packed
	{
		logic [47:0] unused;
		logic sign;
		logic [7:0] exponent;
		logic [6:0] mantissa;
	} bf16_view_t;

	typedef union packed
	{
		logic [63:0] int_val;
		bf16_view_t bf16;
	} scalar_word_u;

	typedef struct packed
	{
		logic valid;
		cast_kind_e kind;
		int_size_e src_size;
		int_size_e dst_size;
		logic is_signed; // signedness of the integer side of the cast.
		scalar_word_u operand;
	} cast_req_t;

	typedef struct packed
	{
		logic valid;
		scalar_word_u data;
	} cast_result_t;

	// keeps the low bits of the given size and clears everything above.
	function automatic logic [63:0] low_bits(input logic [63:0] value, input int_size_e size);
		case (size)
		size_8:
			return {56'd0, value[7:0]};
		size_16:
			return {48'd0, value[15:0]};
		size_32:
			return {32'd0, value[31:0]};
		default:
			return value;
		endcase
	endfunction

	function automatic logic [63:0] sign_extend(input logic [63:0] value,
		input int_size_e size);
		case (size)
		size_8:
			return {{56{value[7]}}, value[7:0]};
		size_16:
			return {{48{value[15]}}, value[15:0]};
		size_32:
			return {{32{value[31]}}, value[31:0]};
		default:
			return value;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- rtl/scalar_cast_unit.sv
`timescale 1ns/1ps
`default_nettype none

module scalar_cast_unit
	import scalar_cast_pkg::*;
(
	input logic clk,
	input logic rst,
	input cast_req_t req,
	output cast_result_t result
);

	scalar_word_u int_data;
	scalar_word_u to_bf16_data;
	scalar_word_u from_bf16_data;

	// every caster works on every request, control picks one result.
	int_scalar_caster int_caster0
	(
		.clk(clk),
		.operand(req.operand),
		.src_size(req.src_size),
		.dst_size(req.dst_size),
		.is_signed(req.is_signed),
		.data(int_data)
	);

	int_to_bfloat16_caster to_bf16_caster0
	(
		.clk(clk),
		.operand(req.operand),
		.src_size(req.src_size),
		.is_signed(req.is_signed),
		.data(to_bf16_data)
	);

	bfloat16_to_int_caster from_bf16_caster0
	(
		.clk(clk),
		.operand(req.operand),
		.dst_size(req.dst_size),
		.is_signed(req.is_signed),
		.data(from_bf16_data)
	);

	cast_control control0
	(
		.clk(clk),
		.rst(rst),
		.req_valid(req.valid),
		.req_kind(req.kind),
		.int_data(int_data),
		.to_bf16_data(to_bf16_data),
		.from_bf16_data(from_bf16_data),
		.result(result)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Compiles the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f flist.f --top-module tb_scalar_cast_unit \
	-Mdir "$build_dir" -o sim_scalar_cast
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

"./$build_dir/sim_scalar_cast" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status."
	exit 1
fi

if grep -qx "TEST PASSED" "$log_file"; then
	exit 0
fi
echo "Pass message not found in $log_file."
exit 1

//--- testbench/tb_scalar_cast_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scalar_cast_unit
	import scalar_cast_pkg::*;
();

	localparam int n_random = 40;
	localparam int n_stream = 300;
	localparam int num_requests = 3 + 64 + 8 + n_random + 15 + n_random + n_stream;
	localparam int cycle_limit = num_requests + 100;

	logic clk = 1'b0;
	logic rst;
	cast_req_t req;
	cast_result_t result;
	logic exp_valid = 1'b0;
	logic [63:0] exp_q[$];
	cast_req_t req_q[$];
	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;

	scalar_cast_unit dut0
	(
		.clk(clk),
		.rst(rst),
		.req(req),
		.result(result)
	);

	initial
	begin
		forever #10 clk = ~clk;
	end

	function automatic logic [63:0] size_mask(input int_size_e size);
		int w;
		w = 8 << int'(size);
		return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
	endfunction

	function automatic logic [63:0] bf16_operand(input logic sign, input logic [7:0] exp,
		input logic [6:0] mant);
		return {48'd0, sign, exp, mant};
	endfunction

	function automatic logic [63:0] cast_expect(input cast_req_t r);
		logic [63:0] src_mask;
		logic [63:0] dst_mask;
		logic [63:0] src_val;
		logic [63:0] wide;
		logic [63:0] mag;
		logic [63:0] res;
		logic [7:0] e;
		logic [7:0] sig;
		logic neg;
		int src_w;
		int p;
		int k;
		src_w = 8 << int'(r.src_size);
		src_mask = size_mask(r.src_size);
		dst_mask = size_mask(r.dst_size);
		src_val = r.operand.int_val & src_mask;
		neg = r.is_signed && src_val[src_w-1];
		wide = neg ? (src_val | ~src_mask) : src_val;
		res = '0;
		case (r.kind)
		kind_int_to_bf16:
		begin
			mag = neg ? -wide : wide;
			if (mag != 64'd0)
			begin
				p = 0;
				for (int i = 0; i < 64; i++)
				begin
					if (mag[i])
					begin
						p = i;
					end
				end
				if (p >= 7)
				begin
					sig = 8'(mag >> (p - 7));
				end
				else
				begin
					sig = 8'(mag << (7 - p));
				end
				res = {48'd0, neg, 8'(127 + p), sig[6:0]};
			end
		end
		kind_bf16_to_int:
		begin
			e = r.operand.int_val[14:7];
			k = int'(e) - 127;
			sig = {1'b1, r.operand.int_val[6:0]};
			neg = r.operand.int_val[15];
			if (e != 8'hff && k >= 0 && k < (r.is_signed ? 63 : 64) && !(neg && !r.is_signed))
			begin
				mag = (k >= 7) ? (64'(sig) << (k - 7)) : (64'(sig) >> (7 - k));
				res = (neg ? -mag : mag) & dst_mask;
			end
		end
		default:
		begin
			res = wide & dst_mask; // narrowing keeps only source bits anyway.
		end
		endcase
		return res;
	endfunction

	task automatic send_request(input cast_kind_e kind, input int_size_e src,
		input int_size_e dst, input logic sgn, input logic [63:0] operand);
		cast_req_t r;
		r.valid = 1'b1;
		r.kind = kind;
		r.src_size = src;
		r.dst_size = dst;
		r.is_signed = sgn;
		r.operand.int_val = operand;
		req = r;
		req_q.push_back(r);
		exp_q.push_back(cast_expect(r));
		@(posedge clk);
		#2;
	endtask

	task automatic idle_cycles(input int n);
		req.valid = 1'b0;
		repeat (n)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	// result.valid must follow the request valid that the DUT sampled one edge earlier.
	always @(posedge clk)
	begin
		exp_valid <= rst ? 1'b0 : req.valid;
	end

	always @(negedge clk)
	begin
		cast_req_t r;
		logic [63:0] e;
		if (result.valid !== exp_valid)
		begin
			value_errors++;
			$display("error at %0t: result.valid is %b, expected %b", $time, result.valid,
				exp_valid);
		end
		if (result.valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				other_errors++;
				$display("A result came out at %0t with no request waiting for it.", $time);
			end
			else
			begin
				r = req_q.pop_front();
				e = exp_q.pop_front();
				if (result.data.int_val !== e)
				begin
					value_errors++;
					$display("error at %0t: kind %0d sizes %0d/%0d signed %b op %h exp %h got %h",
						$time, r.kind, r.src_size, r.dst_size, r.is_signed, r.operand.int_val, e,
						result.data.int_val);
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("The run did not finish within %0d cycles.", cycle_limit);
			$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		logic [63:0] word;
		void'($urandom(32'h6409_bc39));
		req = '0;
		req.valid = 1'b1; // a request during reset must not give a result.
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		idle_cycles(3);

		// isolated requests, each result one cycle later.
		send_request(kind_int_to_int, size_8, size_64, 1'b1, 64'h0000_0000_0000_0080);
		idle_cycles(2);
		send_request(kind_int_to_int, size_64, size_16, 1'b0, 64'h0123_4567_89ab_cdef);
		idle_cycles(2);
		send_request(kind_int_to_int, size_16, size_32, 1'b1, 64'hffff_ffff_ffff_8001);
		idle_cycles(2);

		for (int s = 0; s < 4; s++)
		begin
			for (int d = 0; d < 4; d++)
			begin
				for (int g = 0; g < 2; g++)
				begin
					send_request(kind_int_to_int, int_size_e'(2'(s)), int_size_e'(2'(d)), 1'(g),
						64'hf1e2_d3c4_b5a6_9788);
					send_request(kind_int_to_int, int_size_e'(2'(s)), int_size_e'(2'(d)), 1'(g),
						64'h7152_63c4_35a6_1778);
				end
			end
		end
		idle_cycles(4);

		send_request(kind_int_to_bf16, size_64, size_64, 1'b0, 64'd0);
		send_request(kind_int_to_bf16, size_8, size_64, 1'b0, 64'd1);
		send_request(kind_int_to_bf16, size_8, size_64, 1'b1, 64'h1234_5678_9abc_deff);
		send_request(kind_int_to_bf16, size_8, size_64, 1'b1, 64'h0000_0000_0000_0080);
		send_request(kind_int_to_bf16, size_64, size_64, 1'b0, 64'hffff_ffff_ffff_ffff);
		send_request(kind_int_to_bf16, size_16, size_64, 1'b0, 64'h0000_0000_0000_01ff);
		send_request(kind_int_to_bf16, size_32, size_64, 1'b1, 64'h0000_0000_7fff_ffff);
		send_request(kind_int_to_bf16, size_64, size_64, 1'b1, 64'h8000_0000_0000_0000);
		for (int i = 0; i < n_random; i++)
		begin
			send_request(kind_int_to_bf16, int_size_e'(2'($urandom % 4)), size_64,
				1'($urandom % 2), {$urandom, $urandom});
		end
		idle_cycles(4);

		send_request(kind_bf16_to_int, size_64, size_64, 1'b1, bf16_operand(1'b0, 8'd126, 7'h00));
		send_request(kind_bf16_to_int, size_64, size_32, 1'b0, bf16_operand(1'b0, 8'd126, 7'h7f));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b0, bf16_operand(1'b0, 8'd127, 7'h40));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b1, bf16_operand(1'b1, 8'd128, 7'h20));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b0, bf16_operand(1'b1, 8'd128, 7'h20));
		send_request(kind_bf16_to_int, size_64, size_16, 1'b1, bf16_operand(1'b1, 8'd126, 7'h40));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b1, bf16_operand(1'b0, 8'd189, 7'h00));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b1, bf16_operand(1'b0, 8'd190, 7'h00));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b0, bf16_operand(1'b0, 8'd190, 7'h00));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b0, bf16_operand(1'b0, 8'd191, 7'h00));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b0, bf16_operand(1'b0, 8'd255, 7'h00));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b1, bf16_operand(1'b1, 8'd255, 7'h01));
		send_request(kind_bf16_to_int, size_64, size_8, 1'b0, bf16_operand(1'b0, 8'd135, 7'h16));
		send_request(kind_bf16_to_int, size_64, size_8, 1'b1, bf16_operand(1'b1, 8'd135, 7'h16));
		send_request(kind_bf16_to_int, size_64, size_64, 1'b0, bf16_operand(1'b0, 8'd0, 7'h05));
		for (int i = 0; i < n_random; i++)
		begin
			word = {$urandom, $urandom} & 64'hffff_ffff_ffff_0000; // upper bits are unused.
			word = word | bf16_operand(1'($urandom % 2), 8'(110 + $urandom % 90), 7'($urandom));
			send_request(kind_bf16_to_int, size_64, int_size_e'(2'($urandom % 4)),
				1'($urandom % 2), word);
		end
		idle_cycles(4);

		// back-to-back stream mixing every kind code, the reserved one too.
		for (int i = 0; i < n_stream; i++)
		begin
			word = {$urandom, $urandom};
			if ($urandom % 2 == 0)
			begin
				word[14:7] = 8'(110 + $urandom % 90);
			end
			send_request(cast_kind_e'(2'($urandom % 4)), int_size_e'(2'($urandom % 4)),
				int_size_e'(2'($urandom % 4)), 1'($urandom % 2), word);
		end
		idle_cycles(5);

		if (exp_q.size() != 0)
		begin
			other_errors++;
			$display("%0d requests never produced a result.", exp_q.size());
		end
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
